// File: hdl/dma_copy_engine.sv
// DMA copy engine moving one descriptor as alternating word reads and writes
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_copy_engine (
  input  wire                              clk,
  input  wire                              reset,

  // Table side
  input  wire                              go,
  input  wire [`DMA_TABLE_PTR_WIDTH-1:0]   go_pos,
  input  dma_pkg::dma_request_t            go_req,
  output logic                             idle,
  output logic                             fin,
  output logic [`DMA_TABLE_PTR_WIDTH-1:0]  fin_pos,

  // Memory port
  output dma_pkg::dma_mem_req_t            mem_req,
  input  wire [`DMA_DATA_WIDTH-1:0]        mem_rdata
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_t;

  state_t                            state;
  logic [`DMA_MEM_ADDR_WIDTH-1:0]    src_ptr;
  logic [`DMA_MEM_ADDR_WIDTH-1:0]    dst_ptr;
  logic [`DMA_SIZE_WIDTH-1:0]        remaining;
  logic [`DMA_TABLE_PTR_WIDTH-1:0]   cur_pos;
  logic                              last;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        // Empty transfer goes straight to write, which skips the store
        ST_IDLE:  if (go) state <= (go_req.size == '0) ? ST_WRITE : ST_READ;
        ST_READ:  state <= ST_WRITE;
        ST_WRITE: state <= last ? ST_IDLE : ST_READ;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // Pointers and count
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && go) begin
      cur_pos   <= go_pos;
      remaining <= go_req.size;
      // dir 1 is local to remote
      src_ptr   <= go_req.dir ? go_req.laddr : go_req.raddr;
      dst_ptr   <= go_req.dir ? go_req.raddr : go_req.laddr;
    end else if (state == ST_READ) begin
      src_ptr <= src_ptr + 1'b1;
    end else if (state == ST_WRITE && remaining != '0) begin
      dst_ptr   <= dst_ptr + 1'b1;
      remaining <= remaining - 1'b1;
    end
  end

  // Zero or one word left
  assign last = (remaining[`DMA_SIZE_WIDTH-1:1] == '0);

  assign idle    = (state == ST_IDLE);
  assign fin     = (state == ST_WRITE) && last;
  assign fin_pos = cur_pos;

  //////////////////////////////
  // Memory request
  //////////////////////////////

  // Read data lands the cycle after the strobe, written back directly
  always_comb begin
    mem_req = '0;
    if (state == ST_READ) begin
      mem_req.re   = 1'b1;
      mem_req.addr = src_ptr;
    end else if (state == ST_WRITE && remaining != '0) begin
      mem_req.we    = 1'b1;
      mem_req.addr  = dst_ptr;
      mem_req.wdata = mem_rdata;
    end
  end

  a_re_we_excl: assert property (@(posedge clk) !(mem_req.re && mem_req.we));

  // Table starts work only while the engine is free
  a_go_idle: assert property (@(posedge clk) disable iff (reset) go |-> idle);

endmodule

`default_nettype wire

// File: hdl/dma_defs.svh
// DMA request block widths, descriptor table size and slave register offsets
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Slave port and memory port widths
`define DMA_ADDR_WIDTH 32
`define DMA_DATA_WIDTH 32
`define DMA_MEM_ADDR_WIDTH 16
`define DMA_SIZE_WIDTH 16

// Descriptor table, pointer width 7 at most
`define DMA_TABLE_ENTRIES 4
`define DMA_TABLE_PTR_WIDTH 2

// Byte offsets inside one 32-byte entry window
`define DMA_OFS_LADDR 5'h00
`define DMA_OFS_SIZE 5'h04
`define DMA_OFS_RADDR 5'h08
`define DMA_OFS_CTRL 5'h0C
`define DMA_OFS_STATUS 5'h14

`endif

// File: hdl/dma_interface_ahb.sv
// DMA slave port decoder turning AHB-Lite style accesses into table strobes
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_interface_ahb (
  input  wire                              clk,
  input  wire                              reset,

  // Slave port
  input  wire                              hsel,
  input  wire [`DMA_ADDR_WIDTH-1:0]        haddr,
  input  wire [`DMA_DATA_WIDTH-1:0]        hwdata,
  input  wire                              hwrite,
  input  wire                              hmastlock,
  output logic [`DMA_DATA_WIDTH-1:0]       hrdata,
  output logic                             hready,

  // Table side
  output logic                             wr_en,
  output logic [`DMA_TABLE_PTR_WIDTH-1:0]  wr_pos,
  output dma_pkg::dma_field_sel_t          wr_sel,
  output logic [`DMA_DATA_WIDTH-1:0]       wr_data,
  output logic                             start_en,
  output logic [`DMA_TABLE_PTR_WIDTH-1:0]  st_pos,
  output logic                             rd_ack_en,
  input  wire                              st_done
);

  logic       access;
  logic [4:0] ofs;
  logic       field_hit;
  logic       status_hit;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  // Access completes in the cycle it is presented
  assign access = hsel & hmastlock;
  assign hready = access;

  // Offset within the entry window and entry index from bit 5 up
  assign ofs    = haddr[4:0];
  assign wr_pos = haddr[`DMA_TABLE_PTR_WIDTH+4:5];
  assign st_pos = haddr[`DMA_TABLE_PTR_WIDTH+4:5];

  assign wr_sel.laddr = (ofs == `DMA_OFS_LADDR);
  assign wr_sel.size  = (ofs == `DMA_OFS_SIZE);
  assign wr_sel.raddr = (ofs == `DMA_OFS_RADDR);
  assign wr_sel.ctrl  = (ofs == `DMA_OFS_CTRL);

  assign field_hit  = |wr_sel;
  assign status_hit = (ofs == `DMA_OFS_STATUS);

  // Raw word goes to the table and the table picks the field bits
  assign wr_data = hwdata;

  assign wr_en     = access & hwrite & field_hit;
  // Status write starts the entry and a status read may free it
  assign start_en  = access & hwrite & status_hit;
  assign rd_ack_en = access & ~hwrite & status_hit;

  //////////////////////////////
  // Read data
  //////////////////////////////

  always_comb begin
    hrdata = '0;
    if (status_hit) begin
      hrdata[0] = st_done;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Ready tracks the locked select even in reset
  a_hready_lock: assert property (@(posedge clk) hready == (hsel && hmastlock));

  // Locked accesses carry a known address and direction
  a_access_known: assert property (@(posedge clk) disable iff (reset)
    access |-> !$isunknown({haddr, hwrite}));

endmodule

`default_nettype wire

// File: hdl/dma_pkg.sv
// DMA request block shared types for descriptors, field strobes and memory requests
`default_nettype none

`include "dma_defs.svh"

package dma_pkg;

  // One transfer descriptor as held in the table
  typedef struct packed {
    logic [`DMA_MEM_ADDR_WIDTH-1:0] laddr;
    logic [`DMA_SIZE_WIDTH-1:0]     size;
    logic [`DMA_MEM_ADDR_WIDTH-1:0] raddr;
    // 0 copies remote to local, 1 copies local to remote
    logic                           dir;
  } dma_request_t;

  // Which descriptor field a slave write targets
  typedef struct packed {
    logic laddr;
    logic size;
    logic raddr;
    logic ctrl;
  } dma_field_sel_t;

  // Copy engine memory request, always accepted
  typedef struct packed {
    logic                           re;
    logic                           we;
    logic [`DMA_MEM_ADDR_WIDTH-1:0] addr;
    logic [`DMA_DATA_WIDTH-1:0]     wdata;
  } dma_mem_req_t;

endpackage

`default_nettype wire

// File: hdl/dma_request_table.sv
// DMA descriptor table with valid, busy and done flags and a lowest-index arbiter
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_request_table (
  input  wire                              clk,
  input  wire                              reset,

  // Interface side
  input  wire                              wr_en,
  input  wire [`DMA_TABLE_PTR_WIDTH-1:0]   wr_pos,
  input  dma_pkg::dma_field_sel_t          wr_sel,
  input  wire [`DMA_DATA_WIDTH-1:0]        wr_data,
  input  wire                              start_en,
  input  wire [`DMA_TABLE_PTR_WIDTH-1:0]   st_pos,
  input  wire                              rd_ack_en,
  output logic                             st_done,

  // Engine side
  input  wire                              idle,
  output logic                             go,
  output logic [`DMA_TABLE_PTR_WIDTH-1:0]  go_pos,
  output dma_pkg::dma_request_t            go_req,
  input  wire                              fin,
  input  wire [`DMA_TABLE_PTR_WIDTH-1:0]   fin_pos
);

  dma_pkg::dma_request_t                 req [`DMA_TABLE_ENTRIES];
  logic [`DMA_TABLE_ENTRIES-1:0]         valid;
  logic [`DMA_TABLE_ENTRIES-1:0]         busy;
  logic [`DMA_TABLE_ENTRIES-1:0]         done;
  logic [`DMA_TABLE_ENTRIES-1:0]         pending;
  logic                                  pick_hit;
  logic [`DMA_TABLE_PTR_WIDTH-1:0]       pick_pos;

  //////////////////////////////
  // Descriptor storage
  //////////////////////////////

  // Fields of a valid entry are locked until it is freed
  always_ff @(posedge clk) begin
    if (wr_en && !valid[wr_pos]) begin
      if (wr_sel.laddr) begin
        req[wr_pos].laddr <= wr_data[`DMA_MEM_ADDR_WIDTH-1:0];
      end
      if (wr_sel.size) begin
        req[wr_pos].size <= wr_data[`DMA_SIZE_WIDTH-1:0];
      end
      if (wr_sel.raddr) begin
        req[wr_pos].raddr <= wr_data[`DMA_MEM_ADDR_WIDTH-1:0];
      end
      if (wr_sel.ctrl) begin
        req[wr_pos].dir <= wr_data[0];
      end
    end
  end

  //////////////////////////////
  // Entry flags
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      busy  <= '0;
      done  <= '0;
    end else begin
      // Start, only on a free entry
      if (start_en && !valid[st_pos]) begin
        valid[st_pos] <= 1'b1;
        done[st_pos]  <= 1'b0;
      end
      // Reading a done status frees the entry
      if (rd_ack_en && valid[st_pos] && done[st_pos]) begin
        valid[st_pos] <= 1'b0;
      end
      if (go) begin
        busy[go_pos] <= 1'b1;
      end
      if (fin) begin
        busy[fin_pos] <= 1'b0;
        done[fin_pos] <= 1'b1;
      end
    end
  end

  assign st_done = done[st_pos];

  //////////////////////////////
  // Arbiter
  //////////////////////////////

  assign pending = valid & ~done & ~busy;

  // Walk downward so the lowest pending index wins
  always_comb begin
    pick_hit = 1'b0;
    pick_pos = '0;
    for (int i = `DMA_TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (pending[i]) begin
        pick_hit = 1'b1;
        pick_pos = `DMA_TABLE_PTR_WIDTH'(i);
      end
    end
  end

  assign go     = idle & pick_hit;
  assign go_pos = pick_pos;
  assign go_req = req[pick_pos];

  // Engine only finishes what it was given
  a_fin_busy: assert property (@(posedge clk) disable iff (reset) fin |-> busy[fin_pos]);

  // Never hand out an entry twice
  a_go_free: assert property (@(posedge clk) disable iff (reset) go |-> !busy[go_pos]);

endmodule

`default_nettype wire

// File: hdl/dma_top.sv
// DMA request block top joining slave decoder, descriptor table and copy engine
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_top (
  input  wire                         clk,
  input  wire                         reset,

  // Slave port
  input  wire                         hsel,
  input  wire [`DMA_ADDR_WIDTH-1:0]   haddr,
  input  wire [`DMA_DATA_WIDTH-1:0]   hwdata,
  input  wire                         hwrite,
  input  wire                         hmastlock,
  output logic [`DMA_DATA_WIDTH-1:0]  hrdata,
  output logic                        hready,

  // Memory port
  output dma_pkg::dma_mem_req_t       mem_req,
  input  wire [`DMA_DATA_WIDTH-1:0]   mem_rdata
);

  // Interface to table
  logic                              wr_en;
  logic [`DMA_TABLE_PTR_WIDTH-1:0]   wr_pos;
  dma_pkg::dma_field_sel_t           wr_sel;
  logic [`DMA_DATA_WIDTH-1:0]        wr_data;
  logic                              start_en;
  logic [`DMA_TABLE_PTR_WIDTH-1:0]   st_pos;
  logic                              rd_ack_en;
  logic                              st_done;

  // Table to engine
  logic                              idle;
  logic                              go;
  logic [`DMA_TABLE_PTR_WIDTH-1:0]   go_pos;
  dma_pkg::dma_request_t             go_req;
  logic                              fin;
  logic [`DMA_TABLE_PTR_WIDTH-1:0]   fin_pos;

  dma_interface_ahb u_if (
    .clk, .reset, .hsel, .haddr, .hwdata, .hwrite, .hmastlock, .hrdata, .hready,
    .wr_en, .wr_pos, .wr_sel, .wr_data, .start_en, .st_pos, .rd_ack_en, .st_done
  );

  dma_request_table u_table (
    .clk, .reset, .wr_en, .wr_pos, .wr_sel, .wr_data, .start_en, .st_pos,
    .rd_ack_en, .st_done, .idle, .go, .go_pos, .go_req, .fin, .fin_pos
  );

  dma_copy_engine u_engine (
    .clk, .reset, .go, .go_pos, .go_req, .idle, .fin, .fin_pos, .mem_req, .mem_rdata
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Verilator build and run of the DMA testbench, judged by the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module dma_tb -o dma_sim &&
./obj_dir/dma_sim > sim.log 2>&1 || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^Result: PASSED$" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }

// File: src.f
+incdir+hdl
hdl/dma_pkg.sv
hdl/dma_interface_ahb.sv
hdl/dma_request_table.sv
hdl/dma_copy_engine.sv
hdl/dma_top.sv
verif/dma_tb.sv

// File: verif/dma_tb.sv
// DMA request block testbench with random descriptors, memory model and reference copy
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_tb;

  localparam int CLK_PERIOD = 40;
  localparam int MAX_SIZE   = 16;
  localparam int NUM_XFERS  = 10;
  // Two cycles per word plus bus traffic per transfer, with margin
  localparam int TIMEOUT_CYCLES = 300 + 2 * NUM_XFERS * MAX_SIZE + 24 * NUM_XFERS;

  logic                         clk;
  logic                         reset;
  logic                         hsel;
  logic                         hwrite;
  logic                         hmastlock;
  logic                         hready;
  logic [`DMA_ADDR_WIDTH-1:0]   haddr;
  logic [`DMA_DATA_WIDTH-1:0]   hwdata;
  logic [`DMA_DATA_WIDTH-1:0]   hrdata;
  logic [`DMA_DATA_WIDTH-1:0]   mem_rdata;
  dma_pkg::dma_mem_req_t        mem_req;

  logic [31:0] rng;
  logic [31:0] rd_hold = '0;
  logic [31:0] mem_model [65536];
  logic [31:0] ref_mem [65536];
  // Expected write stream in execution order
  logic [15:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  int          rd_count = 0;
  int          wr_count = 0;
  int          cycle_count = 0;

  dma_top dut0 (
    .clk, .reset, .hsel, .haddr, .hwdata, .hwrite, .hmastlock, .hrdata, .hready,
    .mem_req, .mem_rdata
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Initial memory contents, unique per word address
  function automatic logic [31:0] fill_word(input logic [15:0] a);
    return {~a, a ^ 16'h5aa5};
  endfunction

  function automatic logic [31:0] entry_addr(input int pos, input logic [4:0] ofs);
    return (32'(pos) << 5) | 32'(ofs);
  endfunction

  //////////////////////////////
  // Memory model
  //////////////////////////////

  // Requests sampled at the rising edge, read data driven at the next falling edge
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run("timeout: the DMA transfers did not finish within the cycle limit");
    end
    if (!reset && mem_req.re) begin
      rd_hold  = mem_model[mem_req.addr];
      rd_count = rd_count + 1;
    end
    if (!reset && mem_req.we) begin
      if (exp_addr_q.size() == 0) begin
        abort_run($sformatf("unexpected memory write to address 0x%04h", mem_req.addr));
      end else begin
        check_value("mem_req.addr", 32'(mem_req.addr), 32'(exp_addr_q.pop_front()));
        check_value("mem_req.wdata", mem_req.wdata, exp_data_q.pop_front());
        mem_model[mem_req.addr] = mem_req.wdata;
        wr_count = wr_count + 1;
      end
    end
  end

  always @(negedge clk) begin
    mem_rdata = rd_hold;
  end

  //////////////////////////////
  // Bus tasks
  //////////////////////////////

  // One slave access per cycle, hready checked mid cycle
  task automatic bus_access(input logic sel, input logic lock, input logic wr,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(negedge clk);
    hsel      = sel;
    hmastlock = lock;
    hwrite    = wr;
    haddr     = addr;
    hwdata    = wdata;
    #(CLK_PERIOD / 4);
    check_value("hready", 32'(hready), 32'(sel & lock));
    rdata = hrdata;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, 1'b1, 1'b1, addr, data, unused);
  endtask

  task automatic bus_idle();
    @(negedge clk);
    hsel      = 1'b0;
    hmastlock = 1'b0;
    hwrite    = 1'b0;
  endtask

  task automatic program_entry(input int pos, input dma_pkg::dma_request_t d);
    bus_write(entry_addr(pos, `DMA_OFS_LADDR), 32'(d.laddr));
    bus_write(entry_addr(pos, `DMA_OFS_SIZE), 32'(d.size));
    bus_write(entry_addr(pos, `DMA_OFS_RADDR), 32'(d.raddr));
    bus_write(entry_addr(pos, `DMA_OFS_CTRL), 32'(d.dir));
  endtask

  task automatic start_entry(input int pos);
    bus_write(entry_addr(pos, `DMA_OFS_STATUS), 32'h1);
  endtask

  // Status word holds done in bit 0 only
  task automatic read_status(input int pos, output logic done);
    logic [31:0] data;
    bus_access(1'b1, 1'b1, 1'b0, entry_addr(pos, `DMA_OFS_STATUS), '0, data);
    check_value("hrdata[31:1]", data >> 1, '0);
    done = data[0];
  endtask

  // Poll until done, the done read also frees the entry
  task automatic wait_done(input int pos);
    logic done;
    done = 1'b0;
    while (!done) begin
      read_status(pos, done);
    end
    bus_idle();
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic make_desc(output dma_pkg::dma_request_t d, input logic dir, input int min_size);
    rng     = xorshift32(rng);
    d.laddr = {4'h0, rng[11:0]};
    d.raddr = {4'h0, rng[27:16]};
    rng     = xorshift32(rng);
    d.size  = 16'(min_size + rng % (MAX_SIZE - min_size + 1));
    d.dir   = dir;
  endtask

  // Word by word copy, dir 1 goes local to remote
  task automatic apply_ref(input dma_pkg::dma_request_t d);
    logic [15:0] src;
    logic [15:0] dst;
    src = d.dir ? d.laddr : d.raddr;
    dst = d.dir ? d.raddr : d.laddr;
    for (int i = 0; i < d.size; i++) begin
      ref_mem[dst + 16'(i)] = ref_mem[src + 16'(i)];
      exp_addr_q.push_back(dst + 16'(i));
      exp_data_q.push_back(ref_mem[dst + 16'(i)]);
    end
  endtask

  task automatic check_dest(input dma_pkg::dma_request_t d);
    logic [15:0] a;
    for (int i = 0; i < d.size; i++) begin
      a = (d.dir ? d.raddr : d.laddr) + 16'(i);
      check_value($sformatf("mem_model[0x%04h]", a), mem_model[a], ref_mem[a]);
    end
  endtask

  task automatic run_one(input int pos, input dma_pkg::dma_request_t d);
    program_entry(pos, d);
    apply_ref(d);
    start_entry(pos);
    bus_idle();
    wait_done(pos);
    check_dest(d);
    check_value("pending writes", 32'(exp_addr_q.size()), '0);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    dma_pkg::dma_request_t d;
    dma_pkg::dma_request_t d1;
    dma_pkg::dma_request_t d2;
    dma_pkg::dma_request_t burst [4];
    logic        done;
    logic [31:0] unused;
    int          rd0;
    int          wr0;
    int          p;
    int          q;
    rng       = 32'h09bc9b15;
    reset     = 1'b1;
    hsel      = 1'b0;
    hmastlock = 1'b0;
    hwrite    = 1'b0;
    haddr     = '0;
    hwdata    = '0;
    mem_rdata = '0;
    for (int a = 0; a < 65536; a++) begin
      mem_model[a] = fill_word(16'(a));
      ref_mem[a]   = fill_word(16'(a));
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Quiet after reset, unlocked or unselected starts do nothing
    for (p = 0; p < 4; p++) begin
      read_status(p, done);
      check_value("status done", 32'(done), '0);
    end
    make_desc(d, 1'b0, 1);
    program_entry(0, d);
    bus_access(1'b1, 1'b0, 1'b1, entry_addr(0, `DMA_OFS_STATUS), 32'h1, unused);
    bus_access(1'b0, 1'b1, 1'b1, entry_addr(0, `DMA_OFS_STATUS), 32'h1, unused);
    bus_idle();
    repeat (2 * MAX_SIZE + 4) @(negedge clk);
    read_status(0, done);
    check_value("status done", 32'(done), '0);
    check_value("read count", 32'(rd_count), '0);
    check_value("write count", 32'(wr_count), '0);

    // Remote to local, then local to remote
    make_desc(d, 1'b0, 1);
    run_one(int'(rng[31:30]), d);
    make_desc(d, 1'b1, 1);
    run_one(int'(rng[31:30]), d);

    // Empty descriptor, done without memory traffic
    make_desc(d, rng[0], 0);
    d.size = '0;
    rd0 = rd_count;
    wr0 = wr_count;
    run_one(int'(rng[31:30]), d);
    check_value("read count", 32'(rd_count), 32'(rd0));
    check_value("write count", 32'(wr_count), 32'(wr0));

    // Burst started high to low, entry 3 runs first then lowest index wins
    for (p = 0; p < 4; p++) begin
      make_desc(burst[p], rng[7], (p == 3) ? 4 : 1);
      program_entry(p, burst[p]);
    end
    apply_ref(burst[3]);
    for (p = 0; p < 3; p++) begin
      apply_ref(burst[p]);
    end
    for (p = 3; p >= 0; p--) begin
      start_entry(p);
    end
    bus_idle();
    wait_done(3);
    for (p = 0; p < 3; p++) begin
      wait_done(p);
    end
    for (p = 0; p < 4; p++) begin
      check_dest(burst[p]);
    end

    // Field writes to a queued entry are dropped until it is freed
    p = int'(rng[1:0]);
    q = (p + 1) % 4;
    make_desc(d, 1'b0, 8);
    make_desc(d1, rng[3], 1);
    make_desc(d2, rng[4], 1);
    program_entry(q, d);
    program_entry(p, d1);
    apply_ref(d);
    apply_ref(d1);
    start_entry(q);
    start_entry(p);
    program_entry(p, d2);
    bus_idle();
    wait_done(q);
    wait_done(p);
    check_dest(d);
    check_dest(d1);
    run_one(p, d2);

    // Whole memory against the reference copy
    for (int a = 0; a < 65536; a++) begin
      check_value($sformatf("mem_model[0x%04h]", a), mem_model[a], ref_mem[a]);
    end
    check_value("pending writes", 32'(exp_addr_q.size()), '0);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
